// ==== design/gx_audio_pkg.sv ====
package gx_audio_pkg;

    // Data path and CPU bus widths
    localparam int SAMPLE_W   = 8;
    localparam int CPU_ADDR_W = 16;

    // One audio sample or one register byte
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Sound-effect voice count
    localparam int NUM_VOICES = 4;

    // Register map on the low byte of cpu_addr
    localparam sample_t ADDR_VOL_L  = 8'h40;
    localparam sample_t ADDR_VOL_R  = 8'h41;
    localparam sample_t ADDR_TONE_L = 8'h42;
    localparam sample_t ADDR_TONE_R = 8'h43;

    // Voice register blocks
    localparam sample_t ADDR_VOICE_BASE = 8'h46;
    localparam int      VOICE_STRIDE    = 5;

    // Offsets within one voice block
    // Offset 2 is unused
    localparam int VOICE_OFS_VOL    = 0;
    localparam int VOICE_OFS_FREQ   = 1;
    localparam int VOICE_OFS_PAN    = 3;
    localparam int VOICE_OFS_ACTIVE = 4;

    // High level of a square wave, also the pan complement base
    localparam sample_t FULL_SCALE = 8'hFF;

endpackage

// ==== design/gx_voice_if.sv ====
`timescale 1ns/1ps

interface gx_voice_if
    import gx_audio_pkg::*;
();

    // Static voice setup from the register block
    sample_t volume;
    sample_t freq;
    sample_t pan;
    logic    active;

    modport regs (
        output volume, freq, pan, active
    );

    modport voice (
        input volume, freq, pan, active
    );

endinterface

// ==== design/gx_mix_if.sv ====
`timescale 1ns/1ps

interface gx_mix_if
    import gx_audio_pkg::*;
();

    // Master volumes and tone duty settings per side
    sample_t vol_l;
    sample_t vol_r;
    sample_t tone_l;
    sample_t tone_r;

    modport regs (
        output vol_l, vol_r, tone_l, tone_r
    );

    modport mixer (
        input vol_l, vol_r, tone_l, tone_r
    );

endinterface

// ==== design/gx_audio_regs.sv ====
`timescale 1ns/1ps

module gx_audio_regs
    import gx_audio_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  gx4000_mode,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  sample_t               cpu_data,
    input  logic                  cpu_wr,
    gx_mix_if.regs                mix,
    gx_voice_if.regs              voice [NUM_VOICES]
);

    sample_t addr_lo;
    logic    wr_en;

    // Only the low address byte selects a register
    assign addr_lo = cpu_addr[7:0];
    assign wr_en   = cpu_wr && gx4000_mode;

    // Master volume and tone registers
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mix.vol_l  <= '0;
            mix.vol_r  <= '0;
            mix.tone_l <= '0;
            mix.tone_r <= '0;
        end else if (wr_en) begin
            case (addr_lo)
                ADDR_VOL_L:  mix.vol_l  <= cpu_data;
                ADDR_VOL_R:  mix.vol_r  <= cpu_data;
                ADDR_TONE_L: mix.tone_l <= cpu_data;
                ADDR_TONE_R: mix.tone_r <= cpu_data;
                default: ;
            endcase
        end
    end

    // Mode low freezes the whole register file
    a_mix_hold: assert property (@(posedge clk_sys) disable iff (reset)
        !gx4000_mode |=> $stable({mix.vol_l, mix.vol_r, mix.tone_l, mix.tone_r}));

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        // First address of this voice's block
        localparam sample_t VBASE = sample_t'(ADDR_VOICE_BASE + v * VOICE_STRIDE);

        always_ff @(posedge clk_sys) begin
            if (reset) begin
                voice[v].volume <= '0;
                voice[v].freq   <= '0;
                voice[v].pan    <= '0;
                voice[v].active <= 1'b0;
            end else if (wr_en) begin
                case (addr_lo)
                    sample_t'(VBASE + VOICE_OFS_VOL):  voice[v].volume <= cpu_data;
                    sample_t'(VBASE + VOICE_OFS_FREQ): voice[v].freq   <= cpu_data;
                    sample_t'(VBASE + VOICE_OFS_PAN):  voice[v].pan    <= cpu_data;
                    // Active flag is data bit 0
                    sample_t'(VBASE + VOICE_OFS_ACTIVE): begin
                        voice[v].active <= cpu_data[0];
                    end
                    default: ;
                endcase
            end
        end

        a_voice_hold: assert property (@(posedge clk_sys) disable iff (reset)
            !gx4000_mode |=> $stable({voice[v].volume, voice[v].freq,
                                      voice[v].pan, voice[v].active}));
    end

endmodule

// ==== design/gx_sfx_voice.sv ====
`timescale 1ns/1ps

module gx_sfx_voice
    import gx_audio_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       gx4000_mode,
    gx_voice_if.voice  cfg,
    output sample_t    contrib_l,
    output sample_t    contrib_r
);

    sample_t     phase;
    logic        wave_high;
    logic [23:0] prod_l;
    logic [23:0] prod_r;

    // Phase accumulator, wraps modulo 256
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            phase <= '0;
        end else if (gx4000_mode && cfg.active) begin
            phase <= phase + cfg.freq;
        end
    end

    // Square wave from the phase compare
    assign wave_high = phase < cfg.freq;

    // Level times volume times pan weight
    assign prod_l = FULL_SCALE * cfg.volume * (FULL_SCALE - cfg.pan);
    assign prod_r = FULL_SCALE * cfg.volume * cfg.pan;

    // Keep the top byte of each product
    assign contrib_l = (wave_high && cfg.active) ? prod_l[23:16] : '0;
    assign contrib_r = (wave_high && cfg.active) ? prod_r[23:16] : '0;

    // A silent voice keeps its phase
    a_phase_hold: assert property (@(posedge clk_sys) disable iff (reset)
        !cfg.active |=> $stable(phase));

endmodule

// ==== design/gx_audio_mixer.sv ====
`timescale 1ns/1ps

module gx_audio_mixer
    import gx_audio_pkg::*;
(
    input  logic     clk_sys,
    input  logic     reset,
    input  logic     gx4000_mode,
    gx_mix_if.mixer  cfg,
    input  sample_t  cpc_audio_l,
    input  sample_t  cpc_audio_r,
    input  sample_t  voice_l [NUM_VOICES],
    input  sample_t  voice_r [NUM_VOICES],
    output sample_t  audio_l,
    output sample_t  audio_r
);

    // Index 0 is the left side, index 1 the right
    sample_t side_vol   [2];
    sample_t side_tone  [2];
    sample_t side_host  [2];
    sample_t side_voice [2][NUM_VOICES];
    sample_t side_out   [2];

    assign side_vol[0]   = cfg.vol_l;
    assign side_vol[1]   = cfg.vol_r;
    assign side_tone[0]  = cfg.tone_l;
    assign side_tone[1]  = cfg.tone_r;
    assign side_host[0]  = cpc_audio_l;
    assign side_host[1]  = cpc_audio_r;
    assign side_voice[0] = voice_l;
    assign side_voice[1] = voice_r;

    for (genvar s = 0; s < 2; s++) begin : g_side
        sample_t     tone_phase;
        sample_t     tone_out;
        logic [15:0] host_prod;
        logic [15:0] tone_prod;
        sample_t     voice_sum;
        sample_t     mix_q;

        // Free-running tone phase
        always_ff @(posedge clk_sys) begin
            if (reset) begin
                tone_phase <= '0;
            end else if (gx4000_mode) begin
                tone_phase <= tone_phase + 8'd1;
            end
        end

        // Tone duty set by the tone register
        assign tone_out = (tone_phase < side_tone[s]) ? FULL_SCALE : '0;

        // Master volume on host audio and tone
        assign host_prod = side_host[s] * side_vol[s];
        assign tone_prod = tone_out * side_vol[s];

        // Voice contributions, wrapping sum
        always_comb begin
            voice_sum = '0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                voice_sum = voice_sum + side_voice[s][v];
            end
        end

        always_ff @(posedge clk_sys) begin
            if (reset) begin
                mix_q <= '0;
            end else if (gx4000_mode) begin
                mix_q <= host_prod[15:8] + tone_prod[15:8] + voice_sum;
            end
        end

        assign side_out[s] = mix_q;
    end

    assign audio_l = side_out[0];
    assign audio_r = side_out[1];

    // Outputs freeze while the mode is off
    a_out_hold: assert property (@(posedge clk_sys) disable iff (reset)
        !gx4000_mode |=> $stable({audio_l, audio_r}));

endmodule

// ==== design/gx_audio_top.sv ====
`timescale 1ns/1ps

module gx_audio_top
    import gx_audio_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  gx4000_mode,
    input  logic                  cpu_wr,
    input  logic [CPU_ADDR_W-1:0] cpu_addr,
    input  sample_t               cpu_data,
    input  sample_t               cpc_audio_l,
    input  sample_t               cpc_audio_r,
    output sample_t               audio_l,
    output sample_t               audio_r,
    output logic [NUM_VOICES-1:0] audio_status
);

    gx_mix_if   mix_bus ();
    gx_voice_if voice_bus [NUM_VOICES] ();

    // Per-voice panned levels into the mixer
    sample_t contrib_l [NUM_VOICES];
    sample_t contrib_r [NUM_VOICES];

    gx_audio_regs i_regs (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .cpu_wr      (cpu_wr),
        .mix         (mix_bus),
        .voice       (voice_bus)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        gx_sfx_voice i_voice (
            .clk_sys     (clk_sys),
            .reset       (reset),
            .gx4000_mode (gx4000_mode),
            .cfg         (voice_bus[v]),
            .contrib_l   (contrib_l[v]),
            .contrib_r   (contrib_r[v])
        );

        // Voice 0 reports in the top status bit
        assign audio_status[NUM_VOICES-1-v] = voice_bus[v].active;
    end

    gx_audio_mixer i_mixer (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cfg         (mix_bus),
        .cpc_audio_l (cpc_audio_l),
        .cpc_audio_r (cpc_audio_r),
        .voice_l     (contrib_l),
        .voice_r     (contrib_r),
        .audio_l     (audio_l),
        .audio_r     (audio_r)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_sys,
    output logic reset
);

    // 4 ns period
    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // Held for 16 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk_sys);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== testbench/tb_gx_audio.sv ====
`timescale 1ns/1ps

module tb_gx_audio
    import gx_audio_pkg::*;
();

    localparam int K_SETTLE = 0;
    localparam int K_TONE   = 1;
    localparam int K_VOICE  = 2;
    localparam int K_HOLD   = 3;
    localparam int WATCHDOG_CYCLES = 5000;

    // Writes are applied from index 0 upward
    typedef struct packed {
        logic [1:0]      kind;
        logic [1:0]      voice;
        logic [2:0]      nwr;
        logic            mode;
        logic [0:3][7:0] addr;
        logic [0:3][7:0] data;
        sample_t         host_l;
        sample_t         host_r;
    } step_t;

    logic                  clk_sys;
    logic                  reset;
    logic                  gx4000_mode;
    logic                  cpu_wr;
    logic [CPU_ADDR_W-1:0] cpu_addr;
    sample_t               cpu_data;
    sample_t               cpc_audio_l;
    sample_t               cpc_audio_r;
    sample_t               audio_l;
    sample_t               audio_r;
    logic [NUM_VOICES-1:0] audio_status;

    logic [31:0] lfsr = 32'ha7b7;
    step_t       steps [$];
    int          error_count;
    int          cycles_checked;

    // Reference model state
    // Index 0 is the left side
    int m_vol [2];
    int m_tone [2];
    int m_tphase [2];
    int m_out [2];
    int m_vvol [NUM_VOICES];
    int m_vfreq [NUM_VOICES];
    int m_vpan [NUM_VOICES];
    int m_vact [NUM_VOICES];
    int m_vphase [NUM_VOICES];

    tb_clock_gen i_clk (
        .clk_sys (clk_sys),
        .reset   (reset)
    );

    gx_audio_top i_dut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .gx4000_mode  (gx4000_mode),
        .cpu_wr       (cpu_wr),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpc_audio_l  (cpc_audio_l),
        .cpc_audio_r  (cpc_audio_r),
        .audio_l      (audio_l),
        .audio_r      (audio_r),
        .audio_status (audio_status)
    );

    function automatic sample_t rand_byte();
        sample_t r;
        logic    fb;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            // Taps 32, 22, 2, 1
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[6:0], fb};
        end
        return r;
    endfunction

    function automatic sample_t voice_addr(int v, int ofs);
        return sample_t'(ADDR_VOICE_BASE + v * VOICE_STRIDE + ofs);
    endfunction

    function automatic step_t make_step(int kind, int voice, logic mode, sample_t hl, sample_t hr,
                                        int nwr, logic [0:3][7:0] addr, logic [0:3][7:0] data);
        step_t s;
        s.kind   = 2'(kind);
        s.voice  = 2'(voice);
        s.nwr    = 3'(nwr);
        s.mode   = mode;
        s.addr   = addr;
        s.data   = data;
        s.host_l = hl;
        s.host_r = hr;
        return s;
    endfunction

    // Ungated voice level while the wave is high
    function automatic int pan_level(int v, int side);
        int weight;
        weight = (side == 0) ? 255 - m_vpan[v] : m_vpan[v];
        return (255 * m_vvol[v] * weight) >> 16;
    endfunction

    function automatic int next_mix(int side, int host);
        int total;
        int tone_lvl;
        tone_lvl = (m_tphase[side] < m_tone[side]) ? 255 : 0;
        total = (host * m_vol[side]) >> 8;
        total += (tone_lvl * m_vol[side]) >> 8;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (m_vact[v] != 0 && m_vphase[v] < m_vfreq[v])
                total += pan_level(v, side);
        end
        return total % 256;
    endfunction

    function automatic logic [NUM_VOICES-1:0] model_status();
        logic [NUM_VOICES-1:0] st;
        for (int v = 0; v < NUM_VOICES; v++) begin
            st[NUM_VOICES-1-v] = m_vact[v][0];
        end
        return st;
    endfunction

    task automatic model_write(input int a, input int d);
        int rel;
        rel = a - ADDR_VOICE_BASE;
        case (a)
            ADDR_VOL_L:  m_vol[0] = d;
            ADDR_VOL_R:  m_vol[1] = d;
            ADDR_TONE_L: m_tone[0] = d;
            ADDR_TONE_R: m_tone[1] = d;
            default: begin
                if (rel >= 0 && rel < NUM_VOICES * VOICE_STRIDE) begin
                    case (rel % VOICE_STRIDE)
                        VOICE_OFS_VOL:    m_vvol[rel / VOICE_STRIDE] = d;
                        VOICE_OFS_FREQ:   m_vfreq[rel / VOICE_STRIDE] = d;
                        VOICE_OFS_PAN:    m_vpan[rel / VOICE_STRIDE] = d;
                        VOICE_OFS_ACTIVE: m_vact[rel / VOICE_STRIDE] = d & 1;
                        default: ;
                    endcase
                end
            end
        endcase
    endtask

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] expv);
        assert (got === expv) else begin
            $display("FAIL %s: got %h, expected %h", name, got, expv);
            error_count++;
        end
    endtask

    // Advance DUT and model by one edge and check the registered outputs
    task automatic tick();
        int   nxt_l;
        int   nxt_r;
        int   wr_addr;
        int   wr_data;
        logic mode_now;
        logic wr_now;
        nxt_l = next_mix(0, cpc_audio_l);
        nxt_r = next_mix(1, cpc_audio_r);
        mode_now = gx4000_mode;
        wr_now = cpu_wr;
        wr_addr = cpu_addr[7:0];
        wr_data = cpu_data;
        @(posedge clk_sys);
        if (mode_now) begin
            m_out[0] = nxt_l;
            m_out[1] = nxt_r;
            for (int s = 0; s < 2; s++) begin
                m_tphase[s] = (m_tphase[s] + 1) % 256;
            end
            // Phases move with the freq from before this edge's write
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (m_vact[v] != 0)
                    m_vphase[v] = (m_vphase[v] + m_vfreq[v]) % 256;
            end
            if (wr_now)
                model_write(wr_addr, wr_data);
        end
        #1;
        cycles_checked++;
        compare_value("audio_l", audio_l, 16'(m_out[0]));
        compare_value("audio_r", audio_r, 16'(m_out[1]));
        compare_value("audio_status", audio_status, model_status());
    endtask

    task automatic run_step(input step_t s);
        sample_t               held_l;
        sample_t               held_r;
        logic [NUM_VOICES-1:0] held_st;
        int                    count_l;
        int                    count_r;
        int                    exp_l;
        int                    exp_r;
        held_l = audio_l;
        held_r = audio_r;
        held_st = audio_status;
        gx4000_mode = s.mode;
        cpc_audio_l = s.host_l;
        cpc_audio_r = s.host_r;
        for (int i = 0; i < s.nwr; i++) begin
            cpu_addr = {8'h7f, s.addr[i]};
            cpu_data = s.data[i];
            cpu_wr = 1'b1;
            tick();
        end
        cpu_wr = 1'b0;
        if (s.kind == K_TONE || s.kind == K_VOICE) begin
            // Last write needs two edges to reach the outputs
            tick();
            tick();
            count_l = 0;
            count_r = 0;
            for (int c = 0; c < 256; c++) begin
                tick();
                count_l += (audio_l != 0) ? 1 : 0;
                count_r += (audio_r != 0) ? 1 : 0;
            end
            if (s.kind == K_TONE) begin
                exp_l = (((255 * m_vol[0]) >> 8) != 0) ? m_tone[0] : 0;
                exp_r = (((255 * m_vol[1]) >> 8) != 0) ? m_tone[1] : 0;
            end else begin
                exp_l = (pan_level(s.voice, 0) != 0) ? m_vfreq[s.voice] : 0;
                exp_r = (pan_level(s.voice, 1) != 0) ? m_vfreq[s.voice] : 0;
            end
            compare_value("nonzero cycles of audio_l", 16'(count_l), 16'(exp_l));
            compare_value("nonzero cycles of audio_r", 16'(count_r), 16'(exp_r));
        end else begin
            repeat (8) tick();
            if (s.kind == K_HOLD) begin
                compare_value("audio_l while held", audio_l, held_l);
                compare_value("audio_r while held", audio_r, held_r);
                compare_value("audio_status while held", audio_status, held_st);
            end
        end
    endtask

    task automatic build_table();
        sample_t hl;
        sample_t hr;
        for (int i = 0; i < 2; i++) begin
            steps.push_back(make_step(K_SETTLE, 0, 1'b1, rand_byte(), rand_byte(), 2,
                {ADDR_VOL_L, ADDR_VOL_R, 8'h00, 8'h00}, {rand_byte(), rand_byte(), 16'h0}));
        end
        steps.push_back(make_step(K_TONE, 0, 1'b1, 8'h00, 8'h00, 4,
            {ADDR_VOL_L, ADDR_VOL_R, ADDR_TONE_L, ADDR_TONE_R},
            {8'hff, 8'hff, rand_byte(), rand_byte()}));
        steps.push_back(make_step(K_SETTLE, 0, 1'b1, 8'h00, 8'h00, 4,
            {ADDR_TONE_L, ADDR_TONE_R, ADDR_VOL_L, ADDR_VOL_R}, 32'h0));
        // Single voices that are switched off again afterwards
        for (int v = 1; v < 3; v++) begin
            steps.push_back(make_step(K_VOICE, v, 1'b1, 8'h00, 8'h00, 4,
                {voice_addr(v, VOICE_OFS_VOL), voice_addr(v, VOICE_OFS_FREQ),
                 voice_addr(v, VOICE_OFS_PAN), voice_addr(v, VOICE_OFS_ACTIVE)},
                {rand_byte(), rand_byte(), rand_byte(), 8'h01}));
            steps.push_back(make_step(K_SETTLE, 0, 1'b1, 8'h00, 8'h00, 1,
                {voice_addr(v, VOICE_OFS_ACTIVE), 24'h0}, 32'h0));
        end
        // Voices 0 and 3 loud enough that the sum wraps
        for (int v = 0; v < 4; v += 3) begin
            steps.push_back(make_step(K_SETTLE, 0, 1'b1, 8'h00, 8'h00, 3,
                {voice_addr(v, VOICE_OFS_VOL), voice_addr(v, VOICE_OFS_FREQ),
                 voice_addr(v, VOICE_OFS_PAN), 8'h00},
                {8'hff, rand_byte(), rand_byte(), 8'h00}));
        end
        hl = rand_byte();
        hr = rand_byte();
        steps.push_back(make_step(K_SETTLE, 0, 1'b1, hl, hr, 4,
            {voice_addr(0, VOICE_OFS_ACTIVE), voice_addr(3, VOICE_OFS_ACTIVE),
             ADDR_VOL_L, ADDR_VOL_R}, {8'h03, 8'hff, 8'hff, 8'hff}));
        // Bit 0 clear turns voice 0 off
        steps.push_back(make_step(K_SETTLE, 0, 1'b1, hl, hr, 1,
            {voice_addr(0, VOICE_OFS_ACTIVE), 24'h0}, {8'hfe, 24'h0}));
        steps.push_back(make_step(K_HOLD, 0, 1'b0, rand_byte(), rand_byte(), 4,
            {ADDR_VOL_L, ADDR_TONE_L, voice_addr(1, VOICE_OFS_ACTIVE),
             voice_addr(3, VOICE_OFS_ACTIVE)}, {rand_byte(), rand_byte(), 16'h0100}));
        steps.push_back(make_step(K_SETTLE, 0, 1'b1, hl, hr, 0, 32'h0, 32'h0));
    endtask

    initial begin
        int waited;
        gx4000_mode = 1'b1;
        cpu_wr = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        cpc_audio_l = '0;
        cpc_audio_r = '0;
        error_count = 0;
        cycles_checked = 0;
        build_table();
        waited = 0;
        do begin
            @(negedge clk_sys);
            waited++;
        end while (reset && waited < 64);
        if (reset) begin
            error_count++;
            $display("Timeout: reset still asserted after %0d cycles", waited);
            $display("Errors: %0d in %0d checked cycles", error_count, cycles_checked);
            $display("Finished with errors");
            $finish;
        end else begin
            compare_value("audio_l after reset", audio_l, 16'h0);
            compare_value("audio_r after reset", audio_r, 16'h0);
            compare_value("audio_status after reset", audio_status, 16'h0);
            tick();
            foreach (steps[i]) run_step(steps[i]);
            $display("Errors: %0d in %0d checked cycles over %0d steps",
                     error_count, cycles_checked, steps.size());
            if (error_count == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    initial begin
        for (int n = 0; n < WATCHDOG_CYCLES; n++) @(posedge clk_sys);
        $display("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d in %0d checked cycles", error_count, cycles_checked);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== project.f ====
design/gx_audio_pkg.sv
design/gx_voice_if.sv
design/gx_mix_if.sv
design/gx_audio_regs.sv
design/gx_sfx_voice.sv
design/gx_audio_mixer.sv
design/gx_audio_top.sv
testbench/tb_clock_gen.sv
testbench/tb_gx_audio.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build tb_gx_audio with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_gx_audio -f project.f -o tb_gx_audio; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_gx_audio > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
